// ==== hw/opsum_settings.svh ====
`ifndef OPSUM_SETTINGS_SVH
`define OPSUM_SETTINGS_SVH

// Partial-sum word and its byte lanes
`define OPSUM_DATA_W 32
`define OPSUM_BYTES (`OPSUM_DATA_W / 8)

// Opsum FIFO entries
`define OPSUM_FIFO_DEPTH 8

// Full GLB word address width
`define GLB_ADDR_W 32

// Four banks of 256 rows each
`define GLB_BANK_W 2
`define GLB_ROW_W 8
`define GLB_NUM_BANKS (1 << `GLB_BANK_W)
`define GLB_NUM_ROWS (1 << `GLB_ROW_W)

`endif

// ==== hw/opsum_pkg.sv ====
`include "opsum_settings.svh"

package opsum_pkg;

    // One partial sum as it leaves the reducer
    typedef logic [`OPSUM_DATA_W-1:0] opsum_word_t;

    // Bank and row split of a word address
    typedef struct packed {
        logic [`GLB_ADDR_W-`GLB_BANK_W-`GLB_ROW_W-1:0] pad;
        logic [`GLB_BANK_W-1:0]                         bank;
        logic [`GLB_ROW_W-1:0]                          row;
    } glb_addr_fields_t;

    // Controller and arbiter use flat, the bank array uses fields
    typedef union packed {
        logic [`GLB_ADDR_W-1:0] flat;
        glb_addr_fields_t       fields;
    } glb_addr_u;

endpackage

// ==== hw/opsum_fifo.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module opsum_fifo #(
    parameter int DEPTH = `OPSUM_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   soft_reset_i,
    input  logic                   push_i,
    input  opsum_pkg::opsum_word_t push_data_i,
    input  logic                   pop_i,
    output opsum_pkg::opsum_word_t rd_data_o,
    output logic                   empty_o,
    output logic                   full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    opsum_pkg::opsum_word_t mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   do_push;
    logic                   do_pop;

    // Circular increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // Push into full or pop from empty is ignored
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // First word falls through
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (soft_reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Occupancy holds when both happen together
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/opsum_fifo_ctrl.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module opsum_fifo_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,

    // Strobes from L2
    input  logic                  opsum_fifo_reset_i,
    input  logic                  opsum_need_push_i,
    input  logic                  opsum_need_pop_i,

    // Grant level from the GLB write arbiter
    input  logic                  opsum_permit_pop_i,

    // FIFO flags
    input  logic                  opsum_fifo_empty_i,
    input  logic                  opsum_fifo_full_i,

    // Base from the token engine
    input  logic [`GLB_ADDR_W-1:0] opsum_glb_base_addr_i,

    // FIFO commands
    output logic                  opsum_fifo_reset_o,
    output logic                  opsum_fifo_pop_en_o,
    output logic                  opsum_fifo_push_en_o,

    // Write token towards the arbiter
    output logic                  opsum_glb_write_req_o,
    output opsum_pkg::glb_addr_u  opsum_glb_write_addr_o
);

    localparam int PTR_W = 16;

    logic             pop_pending;
    logic [PTR_W-1:0] write_ptr;

    // A new need_pop wins over the clearing pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_pending <= 1'b0;
        end else if (opsum_need_pop_i) begin
            pop_pending <= 1'b1;
        end else if (opsum_fifo_pop_en_o) begin
            pop_pending <= 1'b0;
        end
    end

    // Word offset from base, advanced once per GLB write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_ptr <= '0;
        end else if (opsum_fifo_reset_i) begin
            write_ptr <= '0;
        end else if (opsum_fifo_pop_en_o) begin
            write_ptr <= write_ptr + 1'b1;
        end
    end

    assign opsum_fifo_reset_o = opsum_fifo_reset_i;

    // Refused pushes are dropped
    assign opsum_fifo_push_en_o = opsum_need_push_i && !opsum_fifo_full_i;

    // Pop only together with the granted GLB write
    assign opsum_fifo_pop_en_o = pop_pending && opsum_permit_pop_i && !opsum_fifo_empty_i;

    assign opsum_glb_write_req_o       = pop_pending && !opsum_fifo_empty_i;
    assign opsum_glb_write_addr_o.flat = opsum_glb_base_addr_i + `GLB_ADDR_W'(write_ptr);

endmodule

// ==== hw/glb_write_arbiter.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module glb_write_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,

    // Opsum write token
    input  logic                    opsum_req_i,
    input  opsum_pkg::glb_addr_u    opsum_addr_i,
    input  opsum_pkg::opsum_word_t  opsum_data_i,
    output logic                    opsum_permit_o,

    // External load port
    input  logic                    ext_wr_req_i,
    input  opsum_pkg::glb_addr_u    ext_wr_addr_i,
    input  opsum_pkg::opsum_word_t  ext_wr_data_i,
    input  logic [`OPSUM_BYTES-1:0] ext_wr_web_i,
    output logic                    ext_wr_grant_o,

    // GLB write port
    output logic                    glb_we_o,
    output opsum_pkg::glb_addr_u    glb_addr_o,
    output opsum_pkg::opsum_word_t  glb_data_o,
    output logic [`OPSUM_BYTES-1:0] glb_web_o
);

    logic last_opsum;  // set when opsum held the port last
    logic opsum_win;
    logic ext_win;

    // On a tie the side not served last goes first
    assign opsum_win = opsum_req_i && (!ext_wr_req_i || !last_opsum);
    assign ext_win   = ext_wr_req_i && !opsum_win;

    assign opsum_permit_o = opsum_win;
    assign ext_wr_grant_o = ext_win;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_opsum <= 1'b0;
        end else if (opsum_win || ext_win) begin
            last_opsum <= opsum_win;
        end
    end

    // Write mux
    always_comb begin
        glb_we_o = opsum_win || ext_win;
        if (opsum_win) begin
            glb_addr_o = opsum_addr_i;
            glb_data_o = opsum_data_i;
            // Partial sums are whole words
            glb_web_o  = '1;
        end else begin
            glb_addr_o = ext_wr_addr_i;
            glb_data_o = ext_wr_data_i;
            glb_web_o  = ext_wr_web_i;
        end
    end

endmodule

// ==== hw/glb_bank_array.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module glb_bank_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we_i,
    input  opsum_pkg::glb_addr_u    wr_addr_i,
    input  opsum_pkg::opsum_word_t  wr_data_i,
    input  logic [`OPSUM_BYTES-1:0] web_i,
    input  logic                    rd_en_i,
    input  opsum_pkg::glb_addr_u    rd_addr_i,
    output opsum_pkg::opsum_word_t  rd_data_o
);

    localparam int NUM_BANKS = `GLB_NUM_BANKS;
    localparam int NUM_ROWS  = `GLB_NUM_ROWS;

    opsum_pkg::opsum_word_t bank_rd_data [NUM_BANKS];
    logic [`GLB_BANK_W-1:0] rd_bank_q;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        opsum_pkg::opsum_word_t mem [NUM_ROWS];
        opsum_pkg::opsum_word_t rd_q;
        logic                   bank_we;
        logic                   bank_re;

        // Only the addressed bank is enabled
        assign bank_we = we_i && (wr_addr_i.fields.bank == `GLB_BANK_W'(b));
        assign bank_re = rd_en_i && (rd_addr_i.fields.bank == `GLB_BANK_W'(b));

        always_ff @(posedge clk) begin
            if (bank_we) begin
                for (int i = 0; i < `OPSUM_BYTES; i++) begin
                    if (web_i[i]) begin
                        mem[wr_addr_i.fields.row][8*i +: 8] <= wr_data_i[8*i +: 8];
                    end
                end
            end
            if (bank_re) begin
                rd_q <= mem[rd_addr_i.fields.row];
            end
        end

        assign bank_rd_data[b] = rd_q;
    end

    // Remember which bank answers next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bank_q <= '0;
        end else if (rd_en_i) begin
            rd_bank_q <= rd_addr_i.fields.bank;
        end
    end

    assign rd_data_o = bank_rd_data[rd_bank_q];

endmodule

// ==== hw/opsum_writeback_top.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module opsum_writeback_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // L2 and reducer side
    input  logic                    fifo_reset_i,
    input  logic                    need_push_i,
    input  opsum_pkg::opsum_word_t  push_data_i,
    input  logic                    need_pop_i,
    input  logic [`GLB_ADDR_W-1:0]  base_addr_i,

    // External load port
    input  logic                    ext_wr_req_i,
    input  opsum_pkg::glb_addr_u    ext_wr_addr_i,
    input  opsum_pkg::opsum_word_t  ext_wr_data_i,
    input  logic [`OPSUM_BYTES-1:0] ext_wr_web_i,
    output logic                    ext_wr_grant_o,

    // GLB read port
    input  logic                    glb_rd_en_i,
    input  opsum_pkg::glb_addr_u    glb_rd_addr_i,
    output opsum_pkg::opsum_word_t  glb_rd_data_o
);

    // FIFO handshake
    logic                   fifo_soft_reset;
    logic                   fifo_push;
    logic                   fifo_pop;
    logic                   fifo_empty;
    logic                   fifo_full;
    opsum_pkg::opsum_word_t fifo_rd_data;

    // Opsum write token
    logic                   opsum_req;
    opsum_pkg::glb_addr_u   opsum_addr;
    logic                   opsum_permit;

    // Arbitrated GLB write
    logic                    glb_we;
    opsum_pkg::glb_addr_u    glb_addr;
    opsum_pkg::opsum_word_t  glb_data;
    logic [`OPSUM_BYTES-1:0] glb_web;

    opsum_fifo i_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .soft_reset_i (fifo_soft_reset),
        .push_i       (fifo_push),
        .push_data_i  (push_data_i),
        .pop_i        (fifo_pop),
        .rd_data_o    (fifo_rd_data),
        .empty_o      (fifo_empty),
        .full_o       (fifo_full)
    );

    opsum_fifo_ctrl i_ctrl (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .opsum_fifo_reset_i     (fifo_reset_i),
        .opsum_need_push_i      (need_push_i),
        .opsum_need_pop_i       (need_pop_i),
        .opsum_permit_pop_i     (opsum_permit),
        .opsum_fifo_empty_i     (fifo_empty),
        .opsum_fifo_full_i      (fifo_full),
        .opsum_glb_base_addr_i  (base_addr_i),
        .opsum_fifo_reset_o     (fifo_soft_reset),
        .opsum_fifo_pop_en_o    (fifo_pop),
        .opsum_fifo_push_en_o   (fifo_push),
        .opsum_glb_write_req_o  (opsum_req),
        .opsum_glb_write_addr_o (opsum_addr)
    );

    glb_write_arbiter i_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .opsum_req_i    (opsum_req),
        .opsum_addr_i   (opsum_addr),
        .opsum_data_i   (fifo_rd_data),
        .opsum_permit_o (opsum_permit),
        .ext_wr_req_i   (ext_wr_req_i),
        .ext_wr_addr_i  (ext_wr_addr_i),
        .ext_wr_data_i  (ext_wr_data_i),
        .ext_wr_web_i   (ext_wr_web_i),
        .ext_wr_grant_o (ext_wr_grant_o),
        .glb_we_o       (glb_we),
        .glb_addr_o     (glb_addr),
        .glb_data_o     (glb_data),
        .glb_web_o      (glb_web)
    );

    glb_bank_array i_glb (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (glb_we),
        .wr_addr_i (glb_addr),
        .wr_data_i (glb_data),
        .web_i     (glb_web),
        .rd_en_i   (glb_rd_en_i),
        .rd_addr_i (glb_rd_addr_i),
        .rd_data_o (glb_rd_data_o)
    );

endmodule

// ==== verif/opsum_writeback_properties.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module opsum_writeback_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     fifo_empty_i,
    input logic                     opsum_req_i,
    input logic                     opsum_permit_i,
    input logic                     ext_req_i,
    input logic                     ext_grant_i,
    input logic                     rd_en_i,
    input logic [`OPSUM_DATA_W-1:0] rd_data_i
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // No opsum token without a head word
    a_req_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_empty_i |-> !opsum_req_i)
    else begin
        $error("opsum write request while the FIFO is empty");
        fail_count++;
    end

    // One GLB writer per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(opsum_permit_i && ext_grant_i))
    else begin
        $error("opsum permit and external grant high together");
        fail_count++;
    end

    a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en_i |=> !$isunknown(rd_data_i))
    else begin
        $error("GLB read data not valid one cycle after the read request");
        fail_count++;
    end

    // Round robin serves each side within two cycles
    a_opsum_served: assert property (@(posedge clk) disable iff (!rst_n)
        opsum_req_i |-> ##[0:2] (opsum_permit_i || !opsum_req_i))
    else begin
        $error("pending opsum write not served within 2 cycles");
        fail_count++;
    end

    a_ext_served: assert property (@(posedge clk) disable iff (!rst_n)
        ext_req_i |-> ##[0:2] (ext_grant_i || !ext_req_i))
    else begin
        $error("external write not served within 2 cycles");
        fail_count++;
    end

endmodule

bind opsum_writeback_top opsum_writeback_properties i_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .fifo_empty_i   (fifo_empty),
    .opsum_req_i    (opsum_req),
    .opsum_permit_i (opsum_permit),
    .ext_req_i      (ext_wr_req_i),
    .ext_grant_i    (ext_wr_grant_o),
    .rd_en_i        (glb_rd_en_i),
    .rd_data_i      (glb_rd_data_o)
);

// ==== verif/opsum_writeback_tb.sv ====
`timescale 1ns/1ps
`include "opsum_settings.svh"

module opsum_writeback_tb;

    // Six tests of at most a few hundred cycles each, with a wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int WAIT_LIMIT = 50;

    logic                    clk;
    logic                    rst_n;
    logic                    fifo_reset_i;
    logic                    need_push_i;
    opsum_pkg::opsum_word_t  push_data_i;
    logic                    need_pop_i;
    logic [`GLB_ADDR_W-1:0]  base_addr_i;
    logic                    ext_wr_req_i;
    opsum_pkg::glb_addr_u    ext_wr_addr_i;
    opsum_pkg::opsum_word_t  ext_wr_data_i;
    logic [`OPSUM_BYTES-1:0] ext_wr_web_i;
    logic                    ext_wr_grant_o;
    logic                    glb_rd_en_i;
    opsum_pkg::glb_addr_u    glb_rd_addr_i;
    opsum_pkg::opsum_word_t  glb_rd_data_o;

    // Reference model of the GLB, the FIFO and the write pointer
    opsum_pkg::opsum_word_t gold [logic [`GLB_ADDR_W-1:0]];
    bit                     touched [logic [`GLB_ADDR_W-1:0]];
    opsum_pkg::opsum_word_t fifo_q [$];
    int unsigned            exp_ptr = 0;
    int unsigned            errors = 0;
    int unsigned            tests = 0;
    int unsigned            cycles = 0;

    opsum_writeback_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [`OPSUM_BYTES-1:0] random_web();
        logic [31:0] rnd;
        rnd = $urandom();
        return rnd[`OPSUM_BYTES-1:0];
    endfunction

    // Merge the enabled bytes into the model
    task automatic record(input logic [`GLB_ADDR_W-1:0] addr, input opsum_pkg::opsum_word_t w,
                          input logic [`OPSUM_BYTES-1:0] web);
        opsum_pkg::opsum_word_t merged;
        merged = gold.exists(addr) ? gold[addr] : '0;
        for (int i = 0; i < `OPSUM_BYTES; i++) begin
            if (web[i]) begin
                merged[8*i +: 8] = w[8*i +: 8];
            end
        end
        gold[addr]    = merged;
        touched[addr] = 1'b1;
    endtask

    task automatic push_word(input opsum_pkg::opsum_word_t w);
        need_push_i = 1'b1;
        push_data_i = w;
        // A push into a full FIFO is lost
        if (fifo_q.size() < `OPSUM_FIFO_DEPTH) begin
            fifo_q.push_back(w);
        end
        next_cycle();
        need_push_i = 1'b0;
    endtask

    // One need_pop pulse, then wait for the GLB write it causes
    task automatic pop_word();
        int n;
        need_pop_i = 1'b1;
        next_cycle();
        need_pop_i = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!i_dut.fifo_pop && n < WAIT_LIMIT);
        if (!i_dut.fifo_pop) begin
            $display("ERROR: opsum write was never granted after need_pop");
            errors++;
            next_cycle();
        end else if (fifo_q.size() == 0) begin
            $display("ERROR: opsum write granted while no word was expected in the FIFO");
            errors++;
            next_cycle();
        end else begin
            next_cycle();
            record(base_addr_i + exp_ptr, fifo_q.pop_front(), '1);
            exp_ptr++;
        end
    endtask

    task automatic ext_write(input logic [`GLB_ADDR_W-1:0] addr, input opsum_pkg::opsum_word_t w,
                             input logic [`OPSUM_BYTES-1:0] web);
        int n;
        ext_wr_req_i       = 1'b1;
        ext_wr_addr_i.flat = addr;
        ext_wr_data_i      = w;
        ext_wr_web_i       = web;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ext_wr_grant_o && n < WAIT_LIMIT);
        if (!ext_wr_grant_o) begin
            $display("ERROR: external write to %h was never granted", addr);
            errors++;
        end else begin
            record(addr, w, web);
        end
        next_cycle();
        ext_wr_req_i = 1'b0;
    endtask

    task automatic read_back(input string name);
        opsum_pkg::opsum_word_t got;
        foreach (touched[a]) begin
            glb_rd_en_i        = 1'b1;
            glb_rd_addr_i.flat = a;
            next_cycle();
            glb_rd_en_i = 1'b0;
            @(negedge clk);
            got = glb_rd_data_o;
            assert (got === gold[a]) else begin
                $display("CHECK FAILED %s: addr %h expected %h actual %h",
                         name, a, gold[a], got);
                errors++;
            end
            next_cycle();
        end
    endtask

    task automatic end_test(input string name, input int unsigned errors_before);
        read_back(name);
        tests++;
        if (errors == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
        end
        touched.delete();
    endtask

    initial begin
        int unsigned          mark;
        int unsigned          total;
        opsum_pkg::glb_addr_u a;
        void'($urandom(48));
        rst_n         = 1'b0;
        fifo_reset_i  = 1'b0;
        need_push_i   = 1'b0;
        push_data_i   = '0;
        need_pop_i    = 1'b0;
        base_addr_i   = '0;
        ext_wr_req_i  = 1'b0;
        ext_wr_addr_i = '0;
        ext_wr_data_i = '0;
        ext_wr_web_i  = '0;
        glb_rd_en_i   = 1'b0;
        glb_rd_addr_i = '0;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();

        mark = errors;
        base_addr_i = 32'h40;
        for (int i = 0; i < 5; i++) push_word($urandom());
        for (int i = 0; i < 5; i++) pop_word();
        end_test("push_pop", mark);

        // Ten pushes against eight entries
        mark = errors;
        for (int i = 0; i < 10; i++) push_word($urandom());
        for (int i = 0; i < `OPSUM_FIFO_DEPTH; i++) pop_word();
        @(negedge clk);
        assert (i_dut.fifo_empty === 1'b1) else begin
            $display("CHECK FAILED full_drop: fifo empty expected 1 actual %b", i_dut.fifo_empty);
            errors++;
        end
        next_cycle();
        end_test("full_drop", mark);

        // External port requests back to back while opsum pops
        mark = errors;
        for (int i = 0; i < 6; i++) push_word($urandom());
        fork
            for (int i = 0; i < 6; i++) pop_word();
            for (int k = 0; k < 12; k++) begin
                // Idle gaps let the external side win ties against opsum
                if (k >= 4) begin
                    repeat (2) next_cycle();
                end
                ext_write(32'h200 + k % 4, $urandom(), (k < 4) ? '1 : random_web());
            end
        join
        end_test("contention", mark);

        mark = errors;
        base_addr_i = 32'h100;
        for (int i = 0; i < 3; i++) push_word($urandom());
        fifo_reset_i = 1'b1;
        next_cycle();
        fifo_reset_i = 1'b0;
        fifo_q.delete();
        exp_ptr = 0;
        for (int i = 0; i < 2; i++) push_word($urandom());
        for (int i = 0; i < 2; i++) pop_word();
        end_test("fifo_reset", mark);

        // Base moves mid-stream, pointer keeps running
        mark = errors;
        base_addr_i = 32'h180;
        for (int i = 0; i < 5; i++) push_word($urandom());
        for (int i = 0; i < 2; i++) pop_word();
        base_addr_i = 32'h1c0;
        for (int i = 0; i < 3; i++) pop_word();
        end_test("base_change", mark);

        mark = errors;
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            a.flat        = '0;
            a.fields.bank = b[`GLB_BANK_W-1:0];
            a.fields.row  = 8'he0;
            // Row e0 in every bank so only the bank bits tell the words apart
            base_addr_i   = a.flat - exp_ptr;
            push_word($urandom());
            pop_word();
        end
        end_test("bank_decode", mark);

        total = errors + i_dut.i_props.fail_count;
        $display("Summary: %0d tests, %0d check errors, %0d assertion failures",
                 tests, errors, i_dut.i_props.fail_count);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/opsum_pkg.sv
hw/opsum_fifo.sv
hw/opsum_fifo_ctrl.sv
hw/glb_write_arbiter.sv
hw/glb_bank_array.sv
hw/opsum_writeback_top.sv
verif/opsum_writeback_properties.sv
verif/opsum_writeback_tb.sv

// ==== Bender.yml ====
package:
  name: opsum_writeback

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/opsum_pkg.sv
      - hw/opsum_fifo.sv
      - hw/opsum_fifo_ctrl.sv
      - hw/glb_write_arbiter.sv
      - hw/glb_bank_array.sv
      - hw/opsum_writeback_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/opsum_writeback_properties.sv
      - verif/opsum_writeback_tb.sv
